// ==== common/trace_pkg.sv ====
package trace_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and counts
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned xlen        = 32;
  localparam int unsigned reg_addr_w  = 5;
  localparam int unsigned trace_depth = 4;
  localparam int unsigned trace_ptr_w = $clog2(trace_depth);
  localparam int unsigned trace_cnt_w = $clog2(trace_depth + 1);

  // instruction word field positions
  localparam int unsigned rd_lsb     = 7;
  localparam int unsigned rs1_lsb    = 15;
  localparam int unsigned rs2_lsb    = 20;
  localparam int unsigned funct3_lsb = 12;
  localparam int unsigned opcode_w   = 7;

  // canonical nop, addi x0, x0, 0
  localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

  ////////////////////////////////////////////////////////////////////////////
  // enums
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [opcode_w-1:0] {
    opc_lui      = 7'b0110111,
    opc_auipc    = 7'b0010111,
    opc_jal      = 7'b1101111,
    opc_jalr     = 7'b1100111,
    opc_branch   = 7'b1100011,
    opc_load     = 7'b0000011,
    opc_store    = 7'b0100011,
    opc_op_imm   = 7'b0010011,
    opc_op       = 7'b0110011,
    opc_misc_mem = 7'b0001111,
    opc_system   = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    cls_nop, cls_lui, cls_auipc, cls_jal, cls_jalr, cls_branch, cls_load,
    cls_store, cls_op_imm, cls_op, cls_fence, cls_system, cls_invalid
  } instr_class_e;

  ////////////////////////////////////////////////////////////////////////////
  // core observation ports
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
    logic            id_valid;
    logic            is_decoding;
    logic            pipe_flush;
  } id_info_t;

  typedef struct packed {
    logic [xlen-1:0] rs1_value;
    logic [xlen-1:0] rs2_value;
  } reg_read_t;

  // valid is ex_valid or wb_valid depending on the stage
  typedef struct packed {
    logic                  valid;
    logic                  we;
    logic [reg_addr_w-1:0] addr;
    logic [xlen-1:0]       wdata;
  } reg_wr_t;

  typedef struct packed {
    logic            req;
    logic            gnt;
    logic            we;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
  } data_acc_t;

  // one retired instruction
  typedef struct packed {
    logic [xlen-1:0]       cycle;
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       instr;
    instr_class_e          cls;
    logic [reg_addr_w-1:0] rs1_addr;
    logic [xlen-1:0]       rs1_value;
    logic [reg_addr_w-1:0] rs2_addr;
    logic [xlen-1:0]       rs2_value;
    logic                  rd_we;
    logic [reg_addr_w-1:0] rd_addr;
    logic [xlen-1:0]       rd_value;
    logic                  mem_valid;
    logic                  mem_we;
    logic [xlen-1:0]       mem_addr;
    logic [xlen-1:0]       mem_wdata;
  } trace_rec_t;

  // later writebacks to the same rd overwrite the traced value
  function automatic trace_rec_t apply_rd_write(trace_rec_t rec, reg_wr_t wr);
    trace_rec_t res;
    res = rec;
    if (wr.we && rec.rd_we && (wr.addr == rec.rd_addr)) begin
      res.rd_value = wr.wdata;
    end
    return res;
  endfunction

endpackage

// ==== decode/instr_classifier.sv ====
`timescale 1ns/10ps

module instr_classifier import trace_pkg::*; (
  input  logic [xlen-1:0]       instr,
  output instr_class_e          cls,
  output logic [reg_addr_w-1:0] rd_addr,
  output logic [reg_addr_w-1:0] rs1_addr,
  output logic [reg_addr_w-1:0] rs2_addr,
  output logic                  reads_rs1,
  output logic                  reads_rs2,
  output logic                  writes_rd
);

  opcode_e    opcode;
  logic [2:0] funct3;

  assign opcode = opcode_e'(instr[opcode_w-1:0]);
  assign funct3 = instr[funct3_lsb +: 3];

  // register indices straight from the word
  assign rd_addr  = instr[rd_lsb +: reg_addr_w];
  assign rs1_addr = instr[rs1_lsb +: reg_addr_w];
  assign rs2_addr = instr[rs2_lsb +: reg_addr_w];

  ////////////////////////////////////////////////////////////////////////////
  // class decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (opcode)
      opc_lui:      cls = cls_lui;
      opc_auipc:    cls = cls_auipc;
      opc_jal:      cls = cls_jal;
      opc_jalr:     cls = cls_jalr;
      // beq/bne/blt/bge/bltu/bgeu only
      opc_branch:   cls = (funct3[2:1] == 2'b01) ? cls_invalid : cls_branch;
      // no ld, no lwu, no 111
      opc_load:     cls = (funct3 == 3'd3 || funct3[2:1] == 2'b11) ? cls_invalid : cls_load;
      // sb, sh, sw
      opc_store:    cls = (funct3 > 3'd2) ? cls_invalid : cls_store;
      opc_op_imm:   cls = (instr == nop_instr) ? cls_nop : cls_op_imm;
      opc_op:       cls = cls_op;
      opc_misc_mem: cls = cls_fence;
      opc_system:   cls = cls_system;
      default:      cls = cls_invalid;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // operand usage per class
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    reads_rs1 = 1'b0;
    reads_rs2 = 1'b0;
    writes_rd = 1'b0;
    case (cls)
      cls_op: begin
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
        writes_rd = 1'b1;
      end
      cls_branch, cls_store: begin
        reads_rs1 = 1'b1;
        reads_rs2 = 1'b1;
      end
      cls_op_imm, cls_load, cls_jalr: begin
        reads_rs1 = 1'b1;
        writes_rd = 1'b1;
      end
      cls_lui, cls_auipc, cls_jal: begin
        writes_rd = 1'b1;
      end
      // csr immediate forms carry a zimm in the rs1 field
      cls_system: begin
        reads_rs1 = ~funct3[2];
        writes_rd = 1'b1;
      end
      default: begin
        reads_rs1 = 1'b0;
      end
    endcase
  end

endmodule

// ==== decode/issue_capture.sv ====
`timescale 1ns/10ps

module issue_capture import trace_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  id_info_t   id,
  input  reg_read_t  rs,
  output logic       new_valid,
  output trace_rec_t new_rec
);

  instr_class_e          cls;
  logic [reg_addr_w-1:0] rd_addr;
  logic [reg_addr_w-1:0] rs1_addr;
  logic [reg_addr_w-1:0] rs2_addr;
  logic                  reads_rs1;
  logic                  reads_rs2;
  logic                  writes_rd;
  logic [xlen-1:0]       cycle_cnt;
  logic                  issue;
  logic                  rd_we;
  trace_rec_t            rec_d;

  instr_classifier i_instr_classifier (
    .instr     (id.instr),
    .cls       (cls),
    .rd_addr   (rd_addr),
    .rs1_addr  (rs1_addr),
    .rs2_addr  (rs2_addr),
    .reads_rs1 (reads_rs1),
    .reads_rs2 (reads_rs2),
    .writes_rd (writes_rd)
  );

  // free running, 0 in the first clock after reset release
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= '0;
    end else begin
      cycle_cnt <= cycle_cnt + 1'b1;
    end
  end

  // flushes and system instructions also leave decode here
  assign issue = id.is_decoding && (id.id_valid || id.pipe_flush);
  assign rd_we = writes_rd && (rd_addr != '0);

  always_comb begin
    rec_d           = '0;
    rec_d.cycle     = cycle_cnt;
    rec_d.pc        = id.pc;
    rec_d.instr     = id.instr;
    rec_d.cls       = cls;
    rec_d.rs1_addr  = reads_rs1 ? rs1_addr : '0;
    rec_d.rs1_value = reads_rs1 ? rs.rs1_value : '0;
    rec_d.rs2_addr  = reads_rs2 ? rs2_addr : '0;
    rec_d.rs2_value = reads_rs2 ? rs.rs2_value : '0;
    rec_d.rd_we     = rd_we;
    rec_d.rd_addr   = rd_we ? rd_addr : '0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      new_valid <= 1'b0;
    end else begin
      new_valid <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      new_rec <= rec_d;
    end
  end

endmodule

// ==== track/trace_fifo.sv ====
`timescale 1ns/10ps

module trace_fifo import trace_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       push,
  input  trace_rec_t push_rec,
  input  logic       pop,
  input  logic       head_upd,
  input  trace_rec_t head_rec,
  output logic       empty,
  output trace_rec_t head
);

  trace_rec_t             mem [trace_depth];
  logic [trace_ptr_w-1:0] rd_ptr;
  logic [trace_ptr_w-1:0] wr_ptr;
  logic [trace_cnt_w-1:0] count;
  logic                   full;
  logic                   push_ok;
  logic                   pop_ok;

  assign empty   = (count == '0);
  assign full    = (count == trace_cnt_w'(trace_depth));
  // a push into a full FIFO is lost
  assign push_ok = push && !full;
  assign pop_ok  = pop && !empty;
  assign head    = mem[rd_ptr];

  // head rewrite and push never hit the same slot while both are legal
  always_ff @(posedge clk) begin
    if (head_upd && !empty) begin
      mem[rd_ptr] <= head_rec;
    end
    if (push_ok) begin
      mem[wr_ptr] <= push_rec;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == trace_ptr_w'(trace_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == trace_ptr_w'(trace_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== track/ex_stage_track.sv ====
`timescale 1ns/10ps

module ex_stage_track import trace_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       in_valid,
  input  trace_rec_t in_rec,
  input  reg_wr_t    ex_wr,
  input  data_acc_t  ex_data,
  input  logic       wb_bypass,
  output logic       out_valid,
  output trace_rec_t out_rec
);

  logic       empty;
  logic       pop;
  trace_rec_t head;
  trace_rec_t head_next;

  trace_fifo i_trace_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (in_valid),
    .push_rec (in_rec),
    .pop      (pop),
    .head_upd (!empty),
    .head_rec (head_next),
    .empty    (empty),
    .head     (head)
  );

  ////////////////////////////////////////////////////////////////////////////
  // head update from this cycle's EX activity
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    head_next = apply_rd_write(head, ex_wr);
    // only the first granted access is kept
    if (ex_data.req && ex_data.gnt && !head.mem_valid) begin
      head_next.mem_valid = 1'b1;
      head_next.mem_we    = ex_data.we;
      head_next.mem_addr  = ex_data.addr;
      head_next.mem_wdata = ex_data.we ? ex_data.wdata : '0;
    end
  end

  // branches leave EX through wb_bypass
  assign pop = !empty && (ex_wr.valid || wb_bypass);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      out_rec <= head_next;
    end
  end

endmodule

// ==== track/wb_stage_track.sv ====
`timescale 1ns/10ps

module wb_stage_track import trace_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       in_valid,
  input  trace_rec_t in_rec,
  input  reg_wr_t    wb_wr,
  output logic       trace_valid,
  output trace_rec_t trace
);

  logic       empty;
  logic       pop;
  trace_rec_t head;
  trace_rec_t head_next;

  trace_fifo i_trace_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (in_valid),
    .push_rec (in_rec),
    .pop      (pop),
    .head_upd (!empty),
    .head_rec (head_next),
    .empty    (empty),
    .head     (head)
  );

  // final rd value, overrides whatever EX saw
  assign head_next = apply_rd_write(head, wb_wr);
  assign pop       = !empty && wb_wr.valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trace_valid <= 1'b0;
    end else begin
      trace_valid <= pop;
    end
  end

  // finished record held until the next retirement
  always_ff @(posedge clk) begin
    if (pop) begin
      trace <= head_next;
    end
  end

endmodule

// ==== verilog/trace_top.sv ====
`timescale 1ns/10ps

module trace_top import trace_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,

  // decode stage
  input  id_info_t   id,
  input  reg_read_t  rs,

  // execute stage
  input  reg_wr_t    ex_wr,
  input  data_acc_t  ex_data,
  input  logic       wb_bypass,

  // writeback stage
  input  reg_wr_t    wb_wr,

  // finished records, in program order
  output logic       trace_valid,
  output trace_rec_t trace
);

  logic       new_valid;
  trace_rec_t new_rec;
  logic       ex_done_valid;
  trace_rec_t ex_done_rec;

  ////////////////////////////////////////////////////////////////////////////
  // issue
  ////////////////////////////////////////////////////////////////////////////

  issue_capture i_issue_capture (
    .clk       (clk),
    .rst_n     (rst_n),
    .id        (id),
    .rs        (rs),
    .new_valid (new_valid),
    .new_rec   (new_rec)
  );

  ////////////////////////////////////////////////////////////////////////////
  // virtual EX and WB stages
  ////////////////////////////////////////////////////////////////////////////

  ex_stage_track i_ex_stage_track (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (new_valid),
    .in_rec    (new_rec),
    .ex_wr     (ex_wr),
    .ex_data   (ex_data),
    .wb_bypass (wb_bypass),
    .out_valid (ex_done_valid),
    .out_rec   (ex_done_rec)
  );

  wb_stage_track i_wb_stage_track (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (ex_done_valid),
    .in_rec      (ex_done_rec),
    .wb_wr       (wb_wr),
    .trace_valid (trace_valid),
    .trace       (trace)
  );

endmodule

// ==== verif/tb_trace_top.sv ====
`timescale 1ns/10ps

module tb_trace_top import trace_pkg::*; ();

  // run limit in clock cycles
  localparam int unsigned timeout_cycles = 2000;

  logic        clk;
  logic        rst_n;
  id_info_t    id;
  reg_read_t   rs;
  reg_wr_t     ex_wr;
  data_acc_t   ex_data;
  logic        wb_bypass;
  reg_wr_t     wb_wr;
  logic        trace_valid;
  trace_rec_t  trace;
  logic [31:0] tb_cycle;
  logic [31:0] lcg_state;
  int unsigned run_cycles = 0;

  trace_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .id          (id),
    .rs          (rs),
    .ex_wr       (ex_wr),
    .ex_data     (ex_data),
    .wb_bypass   (wb_bypass),
    .wb_wr       (wb_wr),
    .trace_valid (trace_valid),
    .trace       (trace)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // issue cycle index counted from the first edge after reset release
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tb_cycle <= '0;
    end else begin
      tb_cycle <= tb_cycle + 32'd1;
    end
  end

  always @(posedge clk) begin
    run_cycles <= run_cycles + 1;
    if (run_cycles >= timeout_cycles) begin
      $display("timeout after %0d cycles, the tests did not complete", run_cycles);
      $display("RESULT: FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // any register except x0
  function automatic logic [4:0] rand_reg();
    return 5'((next_rand() >> 16) % 31 + 1);
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Mismatch %s expected %h actual %h", name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "check of %s failed", name);
    end
  endtask

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic clear_inputs();
    id        = '0;
    rs        = '0;
    ex_wr     = '0;
    ex_data   = '0;
    wb_bypass = 1'b0;
    wb_wr     = '0;
  endtask

  // one decode cycle that returns the fields known at issue
  task automatic issue(input logic [31:0] pc, input logic [31:0] instr,
                       input logic [31:0] rs1v, input logic [31:0] rs2v,
                       output trace_rec_t exp);
    exp            = '0;
    exp.cycle      = tb_cycle;
    exp.pc         = pc;
    exp.instr      = instr;
    id.pc          = pc;
    id.instr       = instr;
    id.id_valid    = 1'b1;
    id.is_decoding = 1'b1;
    rs.rs1_value   = rs1v;
    rs.rs2_value   = rs2v;
    step();
    id.id_valid    = 1'b0;
    id.is_decoding = 1'b0;
  endtask

  // leave EX through ex_valid or through wb_bypass for branches
  task automatic ex_retire(input logic we, input logic [4:0] addr,
                           input logic [31:0] wdata, input logic bypass);
    ex_wr.valid = !bypass;
    ex_wr.we    = we;
    ex_wr.addr  = addr;
    ex_wr.wdata = wdata;
    wb_bypass   = bypass;
    step();
    ex_wr     = '0;
    wb_bypass = 1'b0;
  endtask

  task automatic wb_retire(input logic we, input logic [4:0] addr,
                           input logic [31:0] wdata);
    wb_wr.valid = 1'b1;
    wb_wr.we    = we;
    wb_wr.addr  = addr;
    wb_wr.wdata = wdata;
    step();
    wb_wr = '0;
  endtask

  task automatic wait_for_trace();
    while (trace_valid !== 1'b1) begin
      step();
    end
  endtask

  task automatic check_record(input trace_rec_t exp);
    compare("trace.cycle", exp.cycle, trace.cycle);
    compare("trace.pc", exp.pc, trace.pc);
    compare("trace.instr", exp.instr, trace.instr);
    compare("trace.cls", 32'(exp.cls), 32'(trace.cls));
    compare("trace.rs1_addr", 32'(exp.rs1_addr), 32'(trace.rs1_addr));
    compare("trace.rs1_value", exp.rs1_value, trace.rs1_value);
    compare("trace.rs2_addr", 32'(exp.rs2_addr), 32'(trace.rs2_addr));
    compare("trace.rs2_value", exp.rs2_value, trace.rs2_value);
    compare("trace.rd_we", 32'(exp.rd_we), 32'(trace.rd_we));
    compare("trace.rd_addr", 32'(exp.rd_addr), 32'(trace.rd_addr));
    compare("trace.rd_value", exp.rd_value, trace.rd_value);
    compare("trace.mem_valid", 32'(exp.mem_valid), 32'(trace.mem_valid));
    compare("trace.mem_we", 32'(exp.mem_we), 32'(trace.mem_we));
    compare("trace.mem_addr", exp.mem_addr, trace.mem_addr);
    compare("trace.mem_wdata", exp.mem_wdata, trace.mem_wdata);
  endtask

  // no register or memory activity after issue
  task automatic retire_plain(input trace_rec_t exp);
    step();
    ex_retire(1'b0, '0, '0, 1'b0);
    step();
    wb_retire(1'b0, '0, '0);
    wait_for_trace();
    check_record(exp);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic idle_after_reset();
    repeat (20) begin
      step();
      compare("trace_valid", 32'd0, 32'(trace_valid));
    end
  endtask

  task automatic add_with_ex_write();
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] wd;
    trace_rec_t  exp;
    rs1 = rand_reg();
    rs2 = rand_reg();
    rd  = rand_reg();
    wd  = next_rand();
    issue(32'h100, {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011}, next_rand(), next_rand(), exp);
    exp.cls       = cls_op;
    exp.rs1_addr  = rs1;
    exp.rs1_value = rs.rs1_value;
    exp.rs2_addr  = rs2;
    exp.rs2_value = rs.rs2_value;
    exp.rd_we     = 1'b1;
    exp.rd_addr   = rd;
    exp.rd_value  = wd;
    step();
    ex_retire(1'b1, rd, wd, 1'b0);
    step();
    wb_retire(1'b0, '0, '0);
    wait_for_trace();
    check_record(exp);
  endtask

  // only the first grant is kept and the WB value overrides the EX value
  task automatic load_with_wb_override();
    logic [4:0]  rs1;
    logic [4:0]  rd;
    logic [31:0] addr;
    logic [31:0] wb_val;
    trace_rec_t  exp;
    rs1    = rand_reg();
    rd     = rand_reg();
    addr   = next_rand();
    wb_val = next_rand();
    issue(32'h104, {12'h0, rs1, 3'b010, rd, 7'b0000011}, next_rand(), next_rand(), exp);
    exp.cls       = cls_load;
    exp.rs1_addr  = rs1;
    exp.rs1_value = rs.rs1_value;
    exp.rd_we     = 1'b1;
    exp.rd_addr   = rd;
    exp.rd_value  = wb_val;
    exp.mem_valid = 1'b1;
    exp.mem_addr  = addr;
    step();
    ex_data = '{req: 1'b1, gnt: 1'b1, we: 1'b0, addr: addr, wdata: next_rand()};
    step();
    ex_data.we   = 1'b1;
    ex_data.addr = next_rand();
    ex_retire(1'b1, rd, next_rand(), 1'b0);
    ex_data = '0;
    step();
    wb_retire(1'b1, rd, wb_val);
    wait_for_trace();
    check_record(exp);
  endtask

  task automatic store_access();
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  imm_lo;
    trace_rec_t  exp;
    rs1    = rand_reg();
    rs2    = rand_reg();
    // nonzero imm[4:0] sits where a destination register would be
    imm_lo = rand_reg();
    issue(32'h108, {7'b0, rs2, rs1, 3'b010, imm_lo, 7'b0100011},
          next_rand(), next_rand(), exp);
    exp.cls       = cls_store;
    exp.rs1_addr  = rs1;
    exp.rs1_value = rs.rs1_value;
    exp.rs2_addr  = rs2;
    exp.rs2_value = rs.rs2_value;
    exp.mem_valid = 1'b1;
    exp.mem_we    = 1'b1;
    exp.mem_addr  = next_rand();
    exp.mem_wdata = next_rand();
    step();
    ex_data = '{req: 1'b1, gnt: 1'b1, we: 1'b1, addr: exp.mem_addr, wdata: exp.mem_wdata};
    ex_retire(1'b0, '0, '0, 1'b0);
    ex_data = '0;
    step();
    wb_retire(1'b0, '0, '0);
    wait_for_trace();
    check_record(exp);
  endtask

  task automatic classify_words();
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    trace_rec_t  exp;
    rs1 = rand_reg();
    rs2 = rand_reg();
    rd  = rand_reg();
    issue(32'h200, 32'h0000_0013, next_rand(), next_rand(), exp);
    exp.cls = cls_nop;
    retire_plain(exp);
    // add with rd x0 writes nothing
    issue(32'h204, {7'b0, rs2, rs1, 3'b000, 5'b0, 7'b0110011}, next_rand(), next_rand(), exp);
    exp.cls       = cls_op;
    exp.rs1_addr  = rs1;
    exp.rs1_value = rs.rs1_value;
    exp.rs2_addr  = rs2;
    exp.rs2_value = rs.rs2_value;
    retire_plain(exp);
    issue(32'h208, 32'h0000_007f, next_rand(), next_rand(), exp);
    exp.cls = cls_invalid;
    retire_plain(exp);
    // csrrwi with a zimm in the rs1 field
    issue(32'h20c, {12'h305, 5'd9, 3'b101, rd, 7'b1110011}, next_rand(), next_rand(), exp);
    exp.cls     = cls_system;
    exp.rd_we   = 1'b1;
    exp.rd_addr = rd;
    retire_plain(exp);
  endtask

  task automatic inorder_with_bypass();
    logic [4:0]  rd_a;
    logic [4:0]  rd_c;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    trace_rec_t  exp [3];
    rd_a = rand_reg();
    rd_c = rand_reg();
    rs1  = rand_reg();
    rs2  = rand_reg();
    issue(32'h300, {7'b0, rs2, rs1, 3'b000, rd_a, 7'b0110011}, next_rand(), next_rand(), exp[0]);
    exp[0].cls       = cls_op;
    exp[0].rs1_addr  = rs1;
    exp[0].rs1_value = rs.rs1_value;
    exp[0].rs2_addr  = rs2;
    exp[0].rs2_value = rs.rs2_value;
    exp[0].rd_we     = 1'b1;
    exp[0].rd_addr   = rd_a;
    exp[0].rd_value  = next_rand();
    issue(32'h304, {7'b0, rs2, rs1, 3'b000, 5'b0, 7'b1100011}, next_rand(), next_rand(), exp[1]);
    exp[1].cls       = cls_branch;
    exp[1].rs1_addr  = rs1;
    exp[1].rs1_value = rs.rs1_value;
    exp[1].rs2_addr  = rs2;
    exp[1].rs2_value = rs.rs2_value;
    issue(32'h308, {12'h005, rs1, 3'b000, rd_c, 7'b0010011}, next_rand(), next_rand(), exp[2]);
    exp[2].cls       = cls_op_imm;
    exp[2].rs1_addr  = rs1;
    exp[2].rs1_value = rs.rs1_value;
    exp[2].rd_we     = 1'b1;
    exp[2].rd_addr   = rd_c;
    exp[2].rd_value  = next_rand();
    step();
    ex_retire(1'b1, rd_a, exp[0].rd_value, 1'b0);
    ex_retire(1'b0, '0, '0, 1'b1);
    ex_retire(1'b1, rd_c, exp[2].rd_value, 1'b0);
    step();
    for (int i = 0; i < 3; i++) begin
      wb_retire(1'b0, '0, '0);
      wait_for_trace();
      check_record(exp[i]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    lcg_state = 32'd16;
    clear_inputs();
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    idle_after_reset();
    add_with_ex_write();
    load_with_wb_override();
    store_access();
    classify_words();
    inorder_with_bypass();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== vlog.f ====
common/trace_pkg.sv
decode/instr_classifier.sv
decode/issue_capture.sv
track/trace_fifo.sv
track/ex_stage_track.sv
track/wb_stage_track.sv
verilog/trace_top.sv
verif/tb_trace_top.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_trace_top
FILELIST = vlog.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
